/* vlog.f */
hw/rv_isa_pkg.sv
hw/dec_out_pkg.sv
hw/rv_bus_resp.sv
hw/rv_field_split.sv
hw/rv_imm_gen.sv
hw/rv_op_classify.sv
hw/rv_decoder_top.sv
dv/dec_checker.sv
dv/tb_decoder.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the decoder testbench with Verilator

LOG=sim.log

verilator --binary --timescale 1ns/100ps --top-module tb_decoder -f vlog.f -o tb_decoder
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_decoder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0

/* dv/tb_decoder.sv */
`timescale 1ns/100ps

module tb_decoder;

    import rv_isa_pkg::*;
    import dec_out_pkg::*;

    localparam int NUM_DIRECTED = 20;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_WAIT     = 20;   // Cycles to wait for a strobe

    logic     clk;
    logic     rst;
    logic     stb;
    logic     cyc;
    instr_t   instr;
    op_type_e op_type;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;
    logic     load_rs;
    logic     ack;
    logic     err;
    int       test_cnt;
    int       fail_cnt;
    int       seed;
    int       k;
    int       pick;
    instr_t   w;

    instr_t directed [NUM_DIRECTED] = '{
        32'hfe0a8ce3, 32'h00408463,     // Branch with negative and positive offset
        32'hff5ff0ef, 32'h008000ef,     // JAL
        32'hfe112e23, 32'h00112623,     // Store
        32'hfffff537, 32'h12345517,     // LUI, AUIPC
        32'h00000073, 32'h00100073,     // ECALL, EBREAK
        32'h30200073, 32'h10500073,     // MRET, WFI
        32'h02b50533, 32'h4015d593,     // MUL, SRAI
        32'h00004501, 32'h0c05202f,     // Compressed, AMO
        32'h30529073, 32'h00200073,     // CSRRW, unknown SYSTEM code
        32'h40001033, 32'h00002063      // Bad funct7, bad branch funct3
    };

    rv_decoder_top u_rv_decoder_top (
        .clk_i                (clk),
        .rst_i                (rst),
        .stb_i                (stb),
        .cyc_i                (cyc),
        .instr_i              (instr),
        .instr_op_type_o      (op_type),
        .instr_op_rd_o        (rd),
        .instr_op_rs1_o       (rs1),
        .instr_op_rs2_o       (rs2),
        .instr_op_imm_o       (imm),
        .instr_load_rs1_rs2_o (load_rs),
        .ack_o                (ack),
        .err_o                (err)
    );

    dec_checker u_dec_checker (
        .clk_i      (clk),
        .rst_i      (rst),
        .stb_i      (stb),
        .cyc_i      (cyc),
        .instr_i    (instr),
        .op_type_i  (op_type),
        .rd_i       (rd),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .imm_i      (imm),
        .load_rs_i  (load_rs),
        .ack_i      (ack),
        .err_i      (err),
        .test_cnt_o (test_cnt),
        .fail_cnt_o (fail_cnt)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    function automatic logic [6:0] kept_opcode(input int idx);
        case (idx)
            0: return OPC_BRANCH;
            1: return OPC_LOAD;
            2: return OPC_STORE;
            3: return OPC_OP_IMM;
            4: return OPC_OP;
            5: return OPC_SYSTEM;
            6: return OPC_LUI;
            7: return OPC_AUIPC;
            8: return OPC_JAL;
            9: return OPC_JALR;
            default: return OPC_FENCE;
        endcase
    endfunction

    // Entered and left 1 ns after a rising edge
    task automatic send_request(input instr_t word, input int hold);
        int waited;
        int gap;
        instr  = word;
        stb    = 1'b1;
        cyc    = 1'b1;
        waited = 0;
        while (!(ack || err) && waited < MAX_WAIT) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
        end
        if (!(ack || err)) begin
            $display("No ack or err strobe arrived within %0d cycles for instr %h",
                     MAX_WAIT, word);
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (hold) @(posedge clk);
            #1;
            gap = 1 + ($unsigned($random(seed)) % 2);
            stb = 1'b0;
            cyc = 1'b0;
            repeat (gap) @(posedge clk);
            #1;
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        seed  = 4700;
        rst   = 1'b1;
        stb   = 1'b0;
        cyc   = 1'b0;
        instr = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        for (k = 0; k < NUM_DIRECTED; k++) begin
            send_request(directed[k], 1);
        end
        for (k = 0; k < NUM_RANDOM; k++) begin
            w = $random(seed);
            if (k % 2 == 0) begin   // Kept opcode with mostly legal funct7
                w[6:0] = kept_opcode($unsigned($random(seed)) % 11);
                pick   = $unsigned($random(seed)) % 4;
                if (w[6:0] == OPC_SYSTEM) begin
                    w[14:12] = 3'b000;
                    case (pick)
                        0: w[31:20] = SYS_ECALL;
                        1: w[31:20] = SYS_MRET;
                        2: w[31:20] = SYS_WFI;
                        default: w[31:20] = SYS_EBREAK;
                    endcase
                end else if (pick != 3) begin
                    w[31:25] = (pick == 0) ? F7_BASE : (pick == 1) ? F7_ALT : F7_MULDIV;
                end
            end
            send_request(w, (k % 16 == 7) ? 10 : 1);
        end
        repeat (4) @(posedge clk);
        $display("Tests run %0d, passed %0d, failed %0d",
                 test_cnt, test_cnt - fail_cnt, fail_cnt);
        if (fail_cnt == 0 && test_cnt == NUM_DIRECTED + NUM_RANDOM + 1) begin
            $display("TEST OK");
        end else begin
            if (test_cnt != NUM_DIRECTED + NUM_RANDOM + 1) begin
                $display("Only %0d of %0d tests completed",
                         test_cnt, NUM_DIRECTED + NUM_RANDOM + 1);
            end
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* dv/dec_checker.sv */
`timescale 1ns/100ps

module dec_checker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stb_i,
    input  logic                  cyc_i,
    input  rv_isa_pkg::instr_t    instr_i,
    input  dec_out_pkg::op_type_e op_type_i,
    input  rv_isa_pkg::reg_idx_t  rd_i,
    input  rv_isa_pkg::reg_idx_t  rs1_i,
    input  rv_isa_pkg::reg_idx_t  rs2_i,
    input  rv_isa_pkg::xlen_t     imm_i,
    input  logic                  load_rs_i,
    input  logic                  ack_i,
    input  logic                  err_i,
    output int                    test_cnt_o,
    output int                    fail_cnt_o
);

    import rv_isa_pkg::*;
    import dec_out_pkg::*;

    localparam int ST_IDLE = 0;
    localparam int ST_WAIT = 1;   // Counting edges to the strobe
    localparam int ST_HELD = 2;

    int         state;
    int         edges;
    logic       bad;
    logic       reset_done;
    instr_t     cur;
    op_type_e   exp_op;
    logic [2:0] exp_use;          // {rd, rs1, rs2}
    xlen_t      exp_imm;

    // ==================================================
    // Reference model of the decoding rules
    // ==================================================
    function automatic void decode_model(input instr_t w, output op_type_e op,
                                         output logic [2:0] use_f, output xlen_t imm);
        xlen_t i_imm;
        xlen_t s_imm;
        xlen_t b_imm;
        xlen_t u_imm;
        xlen_t j_imm;
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {w[31:12], 12'h000};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        op    = OP_ILLEGAL;
        use_f = 3'b000;
        imm   = '0;
        case (w[6:0])
            OPC_LUI: begin
                op    = OP_LUI;
                use_f = 3'b100;
                imm   = u_imm;
            end
            OPC_AUIPC: begin
                op    = OP_AUIPC;
                use_f = 3'b100;
                imm   = u_imm;
            end
            OPC_JAL: begin
                op    = OP_JAL;
                use_f = 3'b100;
                imm   = j_imm;
            end
            OPC_JALR: begin
                use_f = 3'b110;
                imm   = i_imm;
                if (w[14:12] == 3'b000) op = OP_JALR;
            end
            OPC_FENCE: begin
                use_f = 3'b110;
                imm   = i_imm;
                if (w[14:12] == 3'b000) op = OP_FENCE;
            end
            OPC_BRANCH: begin
                use_f = 3'b011;
                imm   = b_imm;
                case (w[14:12])
                    3'd0: op = OP_BEQ;
                    3'd1: op = OP_BNE;
                    3'd4: op = OP_BLT;
                    3'd5: op = OP_BGE;
                    3'd6: op = OP_BLTU;
                    3'd7: op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                use_f = 3'b110;
                imm   = i_imm;
                case (w[14:12])
                    3'd0: op = OP_LB;
                    3'd1: op = OP_LH;
                    3'd2: op = OP_LW;
                    3'd4: op = OP_LBU;
                    3'd5: op = OP_LHU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                use_f = 3'b011;
                imm   = s_imm;
                case (w[14:12])
                    3'd0: op = OP_SB;
                    3'd1: op = OP_SH;
                    3'd2: op = OP_SW;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                use_f = 3'b110;
                imm   = i_imm;
                case (w[14:12])
                    3'd0: op = OP_ADDI;
                    3'd2: op = OP_SLTI;
                    3'd3: op = OP_SLTIU;
                    3'd4: op = OP_XORI;
                    3'd6: op = OP_ORI;
                    3'd7: op = OP_ANDI;
                    3'd1: if (w[31:25] == F7_BASE) op = OP_SLLI;
                    default: begin
                        if (w[31:25] == F7_BASE) op = OP_SRLI;
                        if (w[31:25] == F7_ALT) op = OP_SRAI;
                    end
                endcase
            end
            OPC_OP: begin
                use_f = 3'b111;
                case ({w[31:25], w[14:12]})
                    {F7_BASE, 3'd0}: op = OP_ADD;
                    {F7_ALT, 3'd0}:  op = OP_SUB;
                    {F7_BASE, 3'd1}: op = OP_SLL;
                    {F7_BASE, 3'd2}: op = OP_SLT;
                    {F7_BASE, 3'd3}: op = OP_SLTU;
                    {F7_BASE, 3'd4}: op = OP_XOR;
                    {F7_BASE, 3'd5}: op = OP_SRL;
                    {F7_ALT, 3'd5}:  op = OP_SRA;
                    {F7_BASE, 3'd6}: op = OP_OR;
                    {F7_BASE, 3'd7}: op = OP_AND;
                    default: begin
                        // M ops follow funct3 order in the enumeration
                        if (w[31:25] == F7_MULDIV) begin
                            op = op_type_e'(7'(OP_MUL) + {4'b0000, w[14:12]});
                        end
                    end
                endcase
            end
            OPC_SYSTEM: begin
                if (w[14:12] == 3'b000) begin
                    case (w[31:20])
                        SYS_ECALL:  op = OP_ECALL;
                        SYS_EBREAK: op = OP_EBREAK;
                        SYS_MRET:   op = OP_MRET;
                        SYS_WFI:    op = OP_WFI;
                        default:    op = OP_ILLEGAL;
                    endcase
                end
            end
            default: op = OP_ILLEGAL;
        endcase
        if (op == OP_ILLEGAL) begin
            use_f = 3'b000;         // Rejected word reads as all zeros
            imm   = '0;
        end
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: test %0d %s is %h, expected %h",
                     $time, test_cnt_o + 1, what, got, exp);
            bad = 1'b1;
        end
    endtask

    task automatic check_outputs();
        logic illegal;
        illegal = (exp_op == OP_ILLEGAL);
        compare("ack", 32'(ack_i), 32'(!illegal));
        compare("err", 32'(err_i), 32'(illegal));
        compare("op type", 32'(op_type_i), 32'(exp_op));
        compare("rd", 32'(rd_i), exp_use[2] ? 32'(cur[11:7]) : 32'd0);
        compare("rs1", 32'(rs1_i), exp_use[1] ? 32'(cur[19:15]) : 32'd0);
        compare("rs2", 32'(rs2_i), exp_use[0] ? 32'(cur[24:20]) : 32'd0);
        compare("imm", imm_i, exp_imm);
        compare("load flag", 32'(load_rs_i), 32'(|exp_use[1:0]));  // Any source read
    endtask

    task automatic finish_test(input string what);
        test_cnt_o = test_cnt_o + 1;
        if (bad) begin
            fail_cnt_o = fail_cnt_o + 1;
        end
        $display("Test %0d (%s) %s", test_cnt_o, what, bad ? "failed" : "passed");
    endtask

    // ==================================================
    // Mid-cycle monitor
    // ==================================================
    always @(negedge clk_i) begin
        if (rst_i) begin
            state      = ST_IDLE;
            test_cnt_o = 0;
            fail_cnt_o = 0;
            reset_done = 1'b0;
        end else if (!reset_done) begin
            bad = 1'b0;
            compare("ack after reset", 32'(ack_i), 32'd0);
            compare("err after reset", 32'(err_i), 32'd0);
            compare("op type after reset", 32'(op_type_i), 32'd0);
            compare("registers after reset", 32'({rd_i, rs1_i, rs2_i}), 32'd0);
            compare("imm after reset", imm_i, 32'd0);
            compare("load flag after reset", 32'(load_rs_i), 32'd0);
            finish_test("reset state");
            reset_done = 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ack_i || err_i) begin
                        $display("ERR %0t: strobe high with no request pending", $time);
                        fail_cnt_o = fail_cnt_o + 1;
                    end
                    if (stb_i && cyc_i) begin   // Accepted at the next edge
                        cur   = instr_i;
                        decode_model(cur, exp_op, exp_use, exp_imm);
                        edges = 0;
                        bad   = 1'b0;
                        state = ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    edges = edges + 1;
                    if (edges < 3) begin
                        compare("early strobe", 32'({ack_i, err_i}), 32'd0);
                    end else begin
                        check_outputs();
                        state = ST_HELD;
                    end
                end
                default: begin
                    if (stb_i) begin
                        check_outputs();    // Outputs hold while stb_i stays high
                    end else begin
                        compare("strobe after stb_i fell", 32'({ack_i, err_i}), 32'd0);
                        finish_test($sformatf("instr %h", cur));
                        state = ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* hw/rv_decoder_top.sv */
`timescale 1ns/100ps

module rv_decoder_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stb_i,
    input  logic                  cyc_i,
    input  rv_isa_pkg::instr_t    instr_i,
    output dec_out_pkg::op_type_e instr_op_type_o,
    output rv_isa_pkg::reg_idx_t  instr_op_rd_o,
    output rv_isa_pkg::reg_idx_t  instr_op_rs1_o,
    output rv_isa_pkg::reg_idx_t  instr_op_rs2_o,
    output rv_isa_pkg::xlen_t     instr_op_imm_o,
    output logic                  instr_load_rs1_rs2_o,
    output logic                  ack_o,
    output logic                  err_o
);

    import rv_isa_pkg::*;
    import dec_out_pkg::*;

    logic             start;
    logic             s1_valid;
    logic [OPC_W-1:0] s1_opcode;
    logic [F3_W-1:0]  s1_funct3;
    logic [F7_W-1:0]  s1_funct7;
    reg_idx_t         s1_rd;
    reg_idx_t         s1_rs1;
    reg_idx_t         s1_rs2;
    imm_fmt_e         s1_fmt;
    instr_t           s1_raw;
    logic             s2_valid;
    logic             s2_err;

    rv_bus_resp u_rv_bus_resp (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stb_i      (stb_i),
        .cyc_i      (cyc_i),
        .s2_valid_i (s2_valid),
        .s2_err_i   (s2_err),
        .start_o    (start),
        .ack_o      (ack_o),
        .err_o      (err_o)
    );

    rv_field_split u_rv_field_split (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (start),
        .instr_i    (instr_i),
        .s1_valid_o (s1_valid),
        .opcode_o   (s1_opcode),
        .funct3_o   (s1_funct3),
        .funct7_o   (s1_funct7),
        .rd_o       (s1_rd),
        .rs1_o      (s1_rs1),
        .rs2_o      (s1_rs2),
        .fmt_o      (s1_fmt),
        .raw_o      (s1_raw)
    );

    rv_op_classify u_rv_op_classify (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .s1_valid_i (s1_valid),
        .opcode_i   (s1_opcode),
        .funct3_i   (s1_funct3),
        .funct7_i   (s1_funct7),
        .rd_i       (s1_rd),
        .rs1_i      (s1_rs1),
        .rs2_i      (s1_rs2),
        .fmt_i      (s1_fmt),
        .raw_i      (s1_raw),
        .s2_valid_o (s2_valid),
        .s2_err_o   (s2_err),
        .op_type_o  (instr_op_type_o),
        .rd_o       (instr_op_rd_o),
        .rs1_o      (instr_op_rs1_o),
        .rs2_o      (instr_op_rs2_o),
        .imm_o      (instr_op_imm_o),
        .load_rs_o  (instr_load_rs1_rs2_o)
    );

endmodule

/* hw/rv_op_classify.sv */
`timescale 1ns/100ps

module rv_op_classify (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         s1_valid_i,
    input  logic [rv_isa_pkg::OPC_W-1:0] opcode_i,
    input  logic [rv_isa_pkg::F3_W-1:0]  funct3_i,
    input  logic [rv_isa_pkg::F7_W-1:0]  funct7_i,
    input  rv_isa_pkg::reg_idx_t         rd_i,
    input  rv_isa_pkg::reg_idx_t         rs1_i,
    input  rv_isa_pkg::reg_idx_t         rs2_i,
    input  dec_out_pkg::imm_fmt_e        fmt_i,
    input  rv_isa_pkg::instr_t           raw_i,
    output logic                         s2_valid_o,
    output logic                         s2_err_o,
    output dec_out_pkg::op_type_e        op_type_o,
    output rv_isa_pkg::reg_idx_t         rd_o,
    output rv_isa_pkg::reg_idx_t         rs1_o,
    output rv_isa_pkg::reg_idx_t         rs2_o,
    output rv_isa_pkg::xlen_t            imm_o,
    output logic                         load_rs_o
);

    import rv_isa_pkg::*;
    import dec_out_pkg::*;

    op_type_e op_d;
    logic     use_rd;
    logic     use_rs1;
    logic     use_rs2;
    logic     legal;
    xlen_t    imm_w;

    rv_imm_gen u_rv_imm_gen (
        .raw_i (raw_i),
        .fmt_i (fmt_i),
        .imm_o (imm_w)
    );

    // ==================================================
    // Op type and register usage
    // ==================================================
    always_comb begin
        op_d    = OP_ILLEGAL;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode_i)
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3_i)
                    3'b000:  op_d = OP_BEQ;
                    3'b001:  op_d = OP_BNE;
                    3'b100:  op_d = OP_BLT;
                    3'b101:  op_d = OP_BGE;
                    3'b110:  op_d = OP_BLTU;
                    3'b111:  op_d = OP_BGEU;
                    default: op_d = OP_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                case (funct3_i)
                    3'b000:  op_d = OP_LB;
                    3'b001:  op_d = OP_LH;
                    3'b010:  op_d = OP_LW;
                    3'b100:  op_d = OP_LBU;
                    3'b101:  op_d = OP_LHU;
                    default: op_d = OP_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3_i)
                    3'b000:  op_d = OP_SB;
                    3'b001:  op_d = OP_SH;
                    3'b010:  op_d = OP_SW;
                    default: op_d = OP_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                case (funct3_i)
                    3'b000: op_d = OP_ADDI;
                    3'b010: op_d = OP_SLTI;
                    3'b011: op_d = OP_SLTIU;
                    3'b100: op_d = OP_XORI;
                    3'b110: op_d = OP_ORI;
                    3'b111: op_d = OP_ANDI;
                    3'b001: op_d = (funct7_i == F7_BASE) ? OP_SLLI : OP_ILLEGAL;
                    default: begin  // Right shifts
                        if (funct7_i == F7_BASE) begin
                            op_d = OP_SRLI;
                        end else if (funct7_i == F7_ALT) begin
                            op_d = OP_SRAI;
                        end
                    end
                endcase
            end
            OPC_OP: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7_i == F7_BASE) begin
                    case (funct3_i)
                        3'b000: op_d = OP_ADD;
                        3'b001: op_d = OP_SLL;
                        3'b010: op_d = OP_SLT;
                        3'b011: op_d = OP_SLTU;
                        3'b100: op_d = OP_XOR;
                        3'b101: op_d = OP_SRL;
                        3'b110: op_d = OP_OR;
                        default: op_d = OP_AND;
                    endcase
                end else if (funct7_i == F7_MULDIV) begin
                    case (funct3_i)
                        3'b000: op_d = OP_MUL;
                        3'b001: op_d = OP_MULH;
                        3'b010: op_d = OP_MULHSU;
                        3'b011: op_d = OP_MULHU;
                        3'b100: op_d = OP_DIV;
                        3'b101: op_d = OP_DIVU;
                        3'b110: op_d = OP_REM;
                        default: op_d = OP_REMU;
                    endcase
                end else if (funct7_i == F7_ALT) begin
                    if (funct3_i == 3'b000) begin
                        op_d = OP_SUB;
                    end else if (funct3_i == 3'b101) begin
                        op_d = OP_SRA;
                    end
                end
            end
            OPC_LUI: begin
                use_rd = 1'b1;
                op_d   = OP_LUI;
            end
            OPC_AUIPC: begin
                use_rd = 1'b1;
                op_d   = OP_AUIPC;
            end
            OPC_JAL: begin
                use_rd = 1'b1;
                op_d   = OP_JAL;
            end
            OPC_JALR: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                op_d    = (funct3_i == 3'b000) ? OP_JALR : OP_ILLEGAL;
            end
            OPC_FENCE: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                op_d    = (funct3_i == 3'b000) ? OP_FENCE : OP_ILLEGAL;
            end
            OPC_SYSTEM: begin
                if (funct3_i == 3'b000) begin
                    // 12-bit code is funct7 and rs2 fields
                    case ({funct7_i, rs2_i})
                        SYS_ECALL:  op_d = OP_ECALL;
                        SYS_EBREAK: op_d = OP_EBREAK;
                        SYS_MRET:   op_d = OP_MRET;
                        SYS_WFI:    op_d = OP_WFI;
                        default:    op_d = OP_ILLEGAL;
                    endcase
                end
            end
            default: op_d = OP_ILLEGAL;     // C, A, Zicsr and the rest
        endcase
    end

    assign legal = (op_d != OP_ILLEGAL);

    // ==================================================
    // Stage 2 registers
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s2_valid_o <= 1'b0;
            s2_err_o   <= 1'b0;
            op_type_o  <= OP_ILLEGAL;
            rd_o       <= '0;
            rs1_o      <= '0;
            rs2_o      <= '0;
            imm_o      <= '0;
            load_rs_o  <= 1'b0;
        end else begin
            s2_valid_o <= s1_valid_i;
            s2_err_o   <= s1_valid_i & ~legal;
            if (s1_valid_i) begin
                op_type_o <= op_d;
                rd_o      <= (legal && use_rd) ? rd_i : '0;
                rs1_o     <= (legal && use_rs1) ? rs1_i : '0;
                rs2_o     <= (legal && use_rs2) ? rs2_i : '0;
                imm_o     <= legal ? imm_w : '0;
                load_rs_o <= legal & use_rs1;   // Any rs1 reader needs the regfile
            end
        end
    end

endmodule

/* hw/rv_imm_gen.sv */
`timescale 1ns/100ps

module rv_imm_gen (
    input  rv_isa_pkg::instr_t    raw_i,
    input  dec_out_pkg::imm_fmt_e fmt_i,
    output rv_isa_pkg::xlen_t     imm_o
);

    import dec_out_pkg::*;

    always_comb begin
        case (fmt_i)
            FMT_I: begin
                imm_o = {{21{raw_i[31]}}, raw_i[30:20]};
            end
            FMT_S: begin
                imm_o = {{21{raw_i[31]}}, raw_i[30:25], raw_i[11:7]};
            end
            FMT_B: begin
                imm_o = {{20{raw_i[31]}}, raw_i[7], raw_i[30:25], raw_i[11:8], 1'b0};
            end
            FMT_U: begin
                imm_o = {raw_i[31:12], 12'b0};
            end
            // Standard J order imm[20|10:1|11|19:12]
            FMT_J: begin
                imm_o = {{12{raw_i[31]}}, raw_i[19:12], raw_i[20], raw_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;     // R-type and no-operand forms
            end
        endcase
    end

endmodule

/* hw/rv_field_split.sv */
`timescale 1ns/100ps

module rv_field_split (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         start_i,
    input  rv_isa_pkg::instr_t           instr_i,
    output logic                         s1_valid_o,
    output logic [rv_isa_pkg::OPC_W-1:0] opcode_o,
    output logic [rv_isa_pkg::F3_W-1:0]  funct3_o,
    output logic [rv_isa_pkg::F7_W-1:0]  funct7_o,
    output rv_isa_pkg::reg_idx_t         rd_o,
    output rv_isa_pkg::reg_idx_t         rs1_o,
    output rv_isa_pkg::reg_idx_t         rs2_o,
    output dec_out_pkg::imm_fmt_e        fmt_o,
    output rv_isa_pkg::instr_t           raw_o
);

    import rv_isa_pkg::*;
    import dec_out_pkg::*;

    imm_fmt_e fmt_d;

    always_comb begin
        case (instr_i[OPC_LSB +: OPC_W])
            OPC_OP:                                     fmt_d = FMT_R;
            OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_FENCE:  fmt_d = FMT_I;
            OPC_STORE:                                  fmt_d = FMT_S;
            OPC_BRANCH:                                 fmt_d = FMT_B;
            OPC_LUI, OPC_AUIPC:                         fmt_d = FMT_U;
            OPC_JAL:                                    fmt_d = FMT_J;
            default:                                    fmt_d = FMT_NONE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= start_i;  // One-cycle pulse
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            opcode_o <= instr_i[OPC_LSB +: OPC_W];
            funct3_o <= instr_i[F3_LSB +: F3_W];
            funct7_o <= instr_i[F7_LSB +: F7_W];
            rd_o     <= instr_i[RD_LSB +: REG_W];
            rs1_o    <= instr_i[RS1_LSB +: REG_W];
            rs2_o    <= instr_i[RS2_LSB +: REG_W];
            fmt_o    <= fmt_d;
            raw_o    <= instr_i;    // Kept whole for the immediate
        end
    end

endmodule

/* hw/rv_bus_resp.sv */
`timescale 1ns/100ps

module rv_bus_resp (
    input  logic clk_i,
    input  logic rst_i,
    input  logic stb_i,
    input  logic cyc_i,
    input  logic s2_valid_i,
    input  logic s2_err_i,
    output logic start_o,
    output logic ack_o,
    output logic err_o
);

    logic busy_q;   // Request in the pipe
    logic ack_q;
    logic err_q;

    // One request in flight and none while a strobe is held
    assign start_o = stb_i & cyc_i & ~busy_q & ~ack_q & ~err_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            if (start_o) begin
                busy_q <= 1'b1;
            end else if (s2_valid_i) begin
                busy_q <= 1'b0;
            end

            if (s2_valid_i) begin
                ack_q <= ~s2_err_i;
                err_q <= s2_err_i;
            end else begin
                ack_q <= ack_q & stb_i;     // Drop once master lets go
                err_q <= err_q & stb_i;
            end
        end
    end

    assign ack_o = ack_q & stb_i;   // Falls in the same cycle as stb_i
    assign err_o = err_q & stb_i;

endmodule

/* hw/dec_out_pkg.sv */
package dec_out_pkg;

    // ==================================================
    // Decoded op type
    // ==================================================
    // Zero is the illegal code so a rejected word reads as all zeros
    typedef enum logic [6:0] {
        OP_ILLEGAL = 7'd0,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_FENCE,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,      // M extension
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        OP_ECALL, OP_EBREAK, OP_MRET, OP_WFI       // SYSTEM
    } op_type_e;

    // ==================================================
    // Immediate format class
    // ==================================================
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,    // No immediate as for SYSTEM
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } imm_fmt_e;

endpackage

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int ILEN  = 32;
    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // ==================================================
    // Field positions in the 32-bit word
    // ==================================================
    localparam int OPC_LSB = 0;
    localparam int OPC_W   = 7;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int F3_W    = 3;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;
    localparam int F7_W    = 7;

    // ==================================================
    // Opcodes of the kept set
    // ==================================================
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_W-1:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_FENCE  = 7'b0001111;

    localparam logic [F7_W-1:0] F7_BASE   = 7'b0000000;
    localparam logic [F7_W-1:0] F7_ALT    = 7'b0100000; // SUB, SRA, SRAI
    localparam logic [F7_W-1:0] F7_MULDIV = 7'b0000001;

    // SYSTEM code sits in bits 31:20
    localparam logic [11:0] SYS_ECALL  = 12'h000;
    localparam logic [11:0] SYS_EBREAK = 12'h001;
    localparam logic [11:0] SYS_MRET   = 12'h302;
    localparam logic [11:0] SYS_WFI    = 12'h105;

    typedef logic [ILEN-1:0]  instr_t;
    typedef logic [REG_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]  xlen_t;

endpackage
